// ==== common/isa_pkg.sv ====
package isa_pkg;

    // Architectural sizes fixed by the ISA
    localparam int word_width = 32;
    localparam int num_regs   = 32;

    // Data word as held in the register file
    typedef logic [word_width-1:0] word_t;

    // Register index, 0 is the hardwired zero register
    typedef logic [$clog2(num_regs)-1:0] reg_addr_t;

    // Primary opcode field, bits 31:26 of the instruction
    typedef logic [5:0] opcode_t;

    // Function field of R-type instructions, bits 5:0
    typedef logic [5:0] funct_t;

    // Memory access opcodes
    localparam opcode_t op_lw = 6'b100011;
    localparam opcode_t op_sw = 6'b101011;

    // R-type instructions share this opcode and are told apart by funct
    localparam opcode_t op_special = 6'b000000;

    // Multiply, routed to the mult unit
    localparam funct_t funct_mult = 6'b011000;

endpackage

// ==== common/issue_pkg.sv ====
package issue_pkg;

    import isa_pkg::*;

    // Count of functional units behind the issue stage
    localparam int num_units = 3;

    // Functional unit an instruction is sent to
    typedef enum logic [1:0] {
        unit_alu_misc = 2'b00,
        unit_mem      = 2'b01,
        unit_mult     = 2'b10
    } unit_t;

    // Execute controls, carried through issue unchanged
    typedef struct packed {
        logic       sel_alu_shift;
        logic       sel_imm_b;
        logic [2:0] alu_op;
        logic       unsig;
        logic [1:0] shift_op;
        logic [4:0] shift_amt;
        logic       read_mem;
        logic       write_mem;
        logic       sel_wsource;
        // Overflow write enable, no trap is taken here
        logic       write_ov;
    } alu_ctrl_t;

    // Decoded instruction offered by decode
    typedef struct packed {
        opcode_t   op;
        funct_t    funct;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        // High when rt is a source operand
        logic      uses_rt;
        logic      write_reg;
        word_t     imm_ext;
        alu_ctrl_t ctrl;
    } issue_req_t;

    // Operation held in the output register toward execute
    typedef struct packed {
        unit_t     unit;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm_ext;
        reg_addr_t rd;
        logic      write_reg;
        alu_ctrl_t ctrl;
    } exec_op_t;

    // Result returned by a functional unit, always accepted
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } writeback_t;

endpackage

// ==== dv/issue_checks.svh ====
`ifndef ISSUE_CHECKS_SVH
`define ISSUE_CHECKS_SVH

// Register contents as written by the writebacks sent so far
word_t model_regs [num_regs];

// Registers claimed by an accepted instruction and not yet written back
logic model_pend [num_regs];

task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "stopped at time %0t", $time);
endtask

task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
        abort_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    end
endtask

task automatic check_unit(input string name, input unit_t expected, input unit_t actual);
    if (actual !== expected) begin
        abort_run($sformatf("FAILED %s: expected %s (%0d), actual %s (%0d)",
                            name, expected.name(), expected, actual.name(), actual));
    end
endtask

task automatic check_op(input string name, input exec_op_t expected, input exec_op_t actual);
    if (actual !== expected) begin
        abort_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        abort_run($sformatf("FAILED %s: expected %b, actual %b", name, expected, actual));
    end
endtask

task automatic model_reset();
    for (int i = 0; i < num_regs; i++) begin
        model_regs[i] = '0;
        model_pend[i] = 1'b0;
    end
endtask

// Loads and stores go to memory, R-type multiply to the mult unit
function automatic unit_t expect_unit(input opcode_t op, input funct_t funct);
    unit_t unit;
    unit = unit_alu_misc;
    if (op == op_lw || op == op_sw) begin
        unit = unit_mem;
    end
    if (op == op_special && funct == funct_mult) begin
        unit = unit_mult;
    end
    return unit;
endfunction

function automatic word_t model_read(input reg_addr_t addr);
    word_t value;
    if (addr == '0) begin
        value = '0;
    end else begin
        value = model_regs[addr];
    end
    return value;
endfunction

// No bypass, so any pending source or destination holds the request
function automatic logic expect_stall(input issue_req_t req);
    return model_pend[req.rs] || (req.uses_rt && model_pend[req.rt])
           || (req.write_reg && model_pend[req.rd]);
endfunction

function automatic exec_op_t expect_op(input issue_req_t req);
    exec_op_t op;
    op.unit      = expect_unit(req.op, req.funct);
    op.rs_data   = model_read(req.rs);
    op.rt_data   = model_read(req.rt);
    op.imm_ext   = req.imm_ext;
    op.rd        = req.rd;
    op.write_reg = req.write_reg;
    op.ctrl      = req.ctrl;
    return op;
endfunction

// State change at one clock edge, writeback first, then the new claim
task automatic update_model(input logic accept, input issue_req_t req, input writeback_t wbv);
    if (wbv.valid && wbv.rd != '0) begin
        model_regs[wbv.rd] = wbv.data;
        model_pend[wbv.rd] = 1'b0;
    end
    if (accept && req.write_reg && req.rd != '0) begin
        model_pend[req.rd] = 1'b1;
    end
endtask

`endif

// ==== dv/issue_tb.sv ====
module issue_tb;

    import isa_pkg::*;
    import issue_pkg::*;

    localparam int clock_period = 8;
    localparam int num_instr    = 400;

    logic       clock;
    logic       reset;
    issue_req_t dec_req;
    logic       dec_valid;
    logic       dec_ready;
    exec_op_t   ex_op;
    logic       ex_valid;
    logic       ex_ready;
    writeback_t wb;

    int seed;
    int cyc;
    int generated;
    int consumed;

    // Ops accepted and not yet consumed, oldest first
    exec_op_t exp_q [$];

    // Pending writebacks, indexed by the low bits of the edge number
    logic      slot_valid [8];
    reg_addr_t slot_rd    [8];
    word_t     slot_data  [8];

    `include "issue_checks.svh"

    issue_top uut (
        .clock     (clock),
        .reset     (reset),
        .dec_req   (dec_req),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .ex_op     (ex_op),
        .ex_valid  (ex_valid),
        .ex_ready  (ex_ready),
        .wb        (wb)
    );

    always #(clock_period / 2) clock = ~clock;

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    // Small register indices keep hazards frequent
    function automatic issue_req_t make_request();
        issue_req_t req;
        word_t      r;
        word_t      other;
        int         kind;
        r = rand_word();
        other = rand_word();
        req.rs = {2'b00, r[2:0]};
        req.rt = {2'b00, r[5:3]};
        req.rd = {2'b00, r[8:6]};
        req.funct = r[14:9];
        req.ctrl = r[31:15];
        req.imm_ext = rand_word();
        kind = rand_below(16);
        if (kind < 4) begin
            req.op = op_lw;
            req.uses_rt = 1'b0;
            req.write_reg = 1'b1;
        end else if (kind < 7) begin
            req.op = op_sw;
            req.uses_rt = 1'b1;
            req.write_reg = 1'b0;
        end else if (kind < 10) begin
            req.op = op_special;
            req.funct = funct_mult;
            req.uses_rt = 1'b1;
            req.write_reg = 1'b1;
        end else if (kind < 14) begin
            req.op = op_special;
            req.uses_rt = 1'b1;
            req.write_reg = 1'b1;
        end else begin
            req.op = other[5:0];
            req.uses_rt = other[6];
            req.write_reg = other[7];
        end
        return req;
    endfunction

    // Result lands 1 to 6 edges after the consuming edge, one per edge
    task automatic schedule_writeback(input int edge_num, input reg_addr_t rd);
        int         start;
        int         sum;
        logic [2:0] idx;
        logic       found;
        start = rand_below(6);
        found = 1'b0;
        for (int k = 0; k < 6; k++) begin
            sum = edge_num + 1 + (start + k) % 6;
            idx = sum[2:0];
            if (!found && !slot_valid[idx]) begin
                slot_valid[idx] = 1'b1;
                slot_rd[idx] = rd;
                slot_data[idx] = rand_word();
                found = 1'b1;
            end
        end
        if (!found) begin
            abort_run("no free writeback slot within six cycles of a consumed op");
        end
    endtask

    task automatic take_writeback(input int edge_num, output writeback_t next_wb);
        logic [2:0] idx;
        idx = edge_num[2:0];
        next_wb.valid = slot_valid[idx];
        next_wb.rd = slot_rd[idx];
        next_wb.data = slot_data[idx];
        slot_valid[idx] = 1'b0;
    endtask

    initial begin
        #(num_instr * 20 * clock_period);
        abort_run("watchdog expired, the run hung before all instructions drained");
    end

    initial begin
        logic       accept;
        logic       consume;
        logic       out_free;
        writeback_t next_wb;
        seed = 32'h2967;
        clock = 1'b0;
        reset <= 1'b0;
        dec_req <= '0;
        dec_valid <= 1'b0;
        ex_ready <= 1'b0;
        wb <= '0;
        cyc = 0;
        generated = 0;
        consumed = 0;
        accept = 1'b0;
        for (int i = 0; i < 8; i++) begin
            slot_valid[i] = 1'b0;
            slot_rd[i] = '0;
            slot_data[i] = '0;
        end
        model_reset();

        repeat (5) @(posedge clock);
        reset <= 1'b1;
        @(negedge clock);
        check_flag("ex_valid after reset", 1'b0, ex_valid);
        check_flag("dec_ready after reset", 1'b1, dec_ready);

        while (consumed < num_instr) begin
            @(posedge clock);
            cyc++;
            // Decode holds its request until it is taken
            if (!dec_valid || accept) begin
                if (generated < num_instr && rand_below(4) != 0) begin
                    dec_req <= make_request();
                    dec_valid <= 1'b1;
                    generated++;
                end else begin
                    dec_valid <= 1'b0;
                end
            end
            ex_ready <= (rand_below(8) < 5);
            take_writeback(cyc + 1, next_wb);
            wb <= next_wb;

            // Inputs are settled here for edge cyc + 1
            @(negedge clock);
            check_flag("ex_valid", exp_q.size() != 0, ex_valid);
            out_free = (exp_q.size() == 0) || ex_ready;
            check_flag("dec_ready", !expect_stall(dec_req) && out_free, dec_ready);
            accept = dec_valid && dec_ready;
            consume = ex_valid && ex_ready;

            // Front of the queue must sit on ex_op for as long as it is held
            if (ex_valid) begin
                check_unit("ex_op unit", exp_q[0].unit, ex_op.unit);
                check_word("ex_op rs_data", exp_q[0].rs_data, ex_op.rs_data);
                check_word("ex_op rt_data", exp_q[0].rt_data, ex_op.rt_data);
                check_op("ex_op", exp_q[0], ex_op);
            end
            if (consume) begin
                if (exp_q[0].write_reg) begin
                    schedule_writeback(cyc + 1, exp_q[0].rd);
                end
                void'(exp_q.pop_front());
                consumed++;
            end
            if (accept) begin
                exp_q.push_back(expect_op(dec_req));
            end
            update_model(accept, dec_req, wb);
        end

        // The last consumed op leaves execute empty, nothing repeats behind it
        @(negedge clock);
        if (ex_valid === 1'b0) begin
            $display("all tests passed");
            $finish;
        end else begin
            abort_run("ex_valid still high after the last op was consumed");
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module issue_tb -f verilog.f -o issue_sim &&
./obj_dir/issue_sim ||
exit 1

// ==== scoreboard/hazard_detector.sv ====
module hazard_detector (
    input  logic pend_rs,
    input  logic pend_rt,
    input  logic pend_rd,
    input  logic uses_rt,
    input  logic write_reg,
    output logic stall
);

    logic raw_rs;
    logic raw_rt;
    logic waw_rd;

    // Read after write on the sources, no bypass so any pending source waits
    assign raw_rs = pend_rs;
    assign raw_rt = uses_rt && pend_rt;

    // Write after write, keeps writebacks to one register in order
    assign waw_rd = write_reg && pend_rd;

    assign stall = raw_rs || raw_rt || waw_rd;

endmodule

// ==== scoreboard/scoreboard.sv ====
module scoreboard (
    input  logic                  clock,
    input  logic                  reset,
    input  isa_pkg::reg_addr_t    look_rs,
    input  isa_pkg::reg_addr_t    look_rt,
    input  isa_pkg::reg_addr_t    look_rd,
    output logic                  pend_rs,
    output logic                  pend_rt,
    output logic                  pend_rd,
    input  logic                  claim,
    input  isa_pkg::reg_addr_t    claim_rd,
    input  issue_pkg::unit_t      claim_unit,
    input  issue_pkg::writeback_t wb
);

    import isa_pkg::*;
    import issue_pkg::*;

    // One mark vector per unit, a set bit means that unit owns the result.
    // A register is pending when any unit owns it.
    logic [num_regs-1:0] owned [num_units];
    logic [num_regs-1:0] pending;

    logic claim_en;

    // Register 0 is never claimed, so it never stalls
    assign claim_en = claim && (claim_rd != '0);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int u = 0; u < num_units; u++) begin
                owned[u] <= '0;
            end
        end else begin
            // Writeback carries no unit, so release the register everywhere
            if (wb.valid) begin
                for (int u = 0; u < num_units; u++) begin
                    owned[u][wb.rd] <= 1'b0;
                end
            end
            // Claims only target free registers and never meet a release
            if (claim_en) begin
                owned[claim_unit][claim_rd] <= 1'b1;
            end
        end
    end

    always_comb begin
        pending = '0;
        for (int u = 0; u < num_units; u++) begin
            pending = pending | owned[u];
        end
    end

    // Lookups reflect state before the edge
    assign pend_rs = pending[look_rs];
    assign pend_rt = pending[look_rt];
    assign pend_rd = pending[look_rd];

endmodule

// ==== verilog.f ====
+incdir+dv
common/isa_pkg.sv
common/issue_pkg.sv
verilog/register_file.sv
scoreboard/scoreboard.sv
scoreboard/hazard_detector.sv
verilog/issue_stage.sv
verilog/issue_top.sv
dv/issue_tb.sv

// ==== verilog/issue_stage.sv ====
module issue_stage (
    input  logic                  clock,
    input  logic                  reset,
    input  issue_pkg::issue_req_t dec_req,
    input  logic                  dec_valid,
    output logic                  dec_ready,
    output issue_pkg::exec_op_t   ex_op,
    output logic                  ex_valid,
    input  logic                  ex_ready,
    input  issue_pkg::writeback_t wb
);

    import isa_pkg::*;
    import issue_pkg::*;

    word_t    rs_data;
    word_t    rt_data;
    logic     pend_rs;
    logic     pend_rt;
    logic     pend_rd;
    logic     stall;
    logic     out_free;
    logic     accept;
    logic     claim;
    unit_t    op_unit;
    exec_op_t next_op;

    // Route by opcode, R-type multiply goes by funct
    function automatic unit_t classify(opcode_t op, funct_t funct);
        unit_t unit;
        if (op == op_lw || op == op_sw) begin
            unit = unit_mem;
        end else if (op == op_special && funct == funct_mult) begin
            unit = unit_mult;
        end else begin
            unit = unit_alu_misc;
        end
        return unit;
    endfunction

    register_file u_register_file (
        .clock   (clock),
        .reset   (reset),
        .raddr_a (dec_req.rs),
        .raddr_b (dec_req.rt),
        .rdata_a (rs_data),
        .rdata_b (rt_data),
        .wb      (wb)
    );

    scoreboard u_scoreboard (
        .clock      (clock),
        .reset      (reset),
        .look_rs    (dec_req.rs),
        .look_rt    (dec_req.rt),
        .look_rd    (dec_req.rd),
        .pend_rs    (pend_rs),
        .pend_rt    (pend_rt),
        .pend_rd    (pend_rd),
        .claim      (claim),
        .claim_rd   (dec_req.rd),
        .claim_unit (op_unit),
        .wb         (wb)
    );

    hazard_detector u_hazard_detector (
        .pend_rs   (pend_rs),
        .pend_rt   (pend_rt),
        .pend_rd   (pend_rd),
        .uses_rt   (dec_req.uses_rt),
        .write_reg (dec_req.write_reg),
        .stall     (stall)
    );

    // Output slot can take a new op when empty or drained this cycle
    assign out_free  = !ex_valid || ex_ready;
    assign dec_ready = !stall && out_free;
    assign accept    = dec_valid && dec_ready;

    // Destination marked pending on the accepting edge
    assign claim = accept && dec_req.write_reg;

    assign op_unit = classify(dec_req.op, dec_req.funct);

    always_comb begin
        next_op.unit      = op_unit;
        next_op.rs_data   = rs_data;
        next_op.rt_data   = rt_data;
        next_op.imm_ext   = dec_req.imm_ext;
        next_op.rd        = dec_req.rd;
        next_op.write_reg = dec_req.write_reg;
        next_op.ctrl      = dec_req.ctrl;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ex_valid <= 1'b0;
        end else if (accept) begin
            ex_valid <= 1'b1;
        end else if (ex_ready) begin
            ex_valid <= 1'b0;
        end
    end

    // Held while execute stalls, since accept needs a free slot
    always_ff @(posedge clock) begin
        if (accept) begin
            ex_op <= next_op;
        end
    end

endmodule

// ==== verilog/issue_top.sv ====
module issue_top (
    input  logic                  clock,
    input  logic                  reset,

    // Decode side
    input  issue_pkg::issue_req_t dec_req,
    input  logic                  dec_valid,
    output logic                  dec_ready,

    // Execute side
    output issue_pkg::exec_op_t   ex_op,
    output logic                  ex_valid,
    input  logic                  ex_ready,

    // Results from the functional units
    input  issue_pkg::writeback_t wb
);

    issue_stage u_issue_stage (
        .clock     (clock),
        .reset     (reset),
        .dec_req   (dec_req),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .ex_op     (ex_op),
        .ex_valid  (ex_valid),
        .ex_ready  (ex_ready),
        .wb        (wb)
    );

endmodule

// ==== verilog/register_file.sv ====
module register_file (
    input  logic                  clock,
    input  logic                  reset,
    input  isa_pkg::reg_addr_t    raddr_a,
    input  isa_pkg::reg_addr_t    raddr_b,
    output isa_pkg::word_t        rdata_a,
    output isa_pkg::word_t        rdata_b,
    input  issue_pkg::writeback_t wb
);

    import isa_pkg::*;

    // Register 0 has no storage
    word_t regs [1:num_regs-1];

    logic wr_en;

    assign wr_en = wb.valid && (wb.rd != '0);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Reads see the contents before a write on the same edge
    always_comb begin
        if (raddr_a == '0) begin
            rdata_a = '0;
        end else begin
            rdata_a = regs[raddr_a];
        end
    end

    always_comb begin
        if (raddr_b == '0) begin
            rdata_b = '0;
        end else begin
            rdata_b = regs[raddr_b];
        end
    end

endmodule
